// File: disk_pkg.sv
package disk_pkg;

	// ========================================================================
	// Sizes and timing constants
	// ========================================================================

	// Hard-disk ports behind the host
	localparam int NUM_DRIVES = 2;
	localparam int DRIVE_SEL_W = (NUM_DRIVES > 1) ? $clog2(NUM_DRIVES) : 1;

	// Cycles the disk LED stays lit after the last request
	localparam int LED_HOLD_CYCLES = 48;
	localparam int LED_COUNT_W = $clog2(LED_HOLD_CYCLES + 1);

	// Length of the system reset pulse
	localparam int RESET_PULSE_CYCLES = 8;

	// ========================================================================
	// Vector types
	// ========================================================================

	typedef logic [15:0] word_t;
	typedef logic [DRIVE_SEL_W-1:0] drive_sel_t;
	// Nonzero while the drive wants service
	typedef logic [2:0] drive_req_t;
	typedef logic [15:0] mgmt_addr_t;
	typedef logic [31:0] mgmt_data_t;
	typedef logic [LED_COUNT_W-1:0] led_count_t;
	typedef logic [RESET_PULSE_CYCLES-1:0] rst_pulse_t;

	// ========================================================================
	// Bundles
	// ========================================================================

	// Sector data command towards one drive
	typedef struct packed {
		logic write;
		logic read;
		word_t writedata;
	} drive_cmd_t;

	// Management bus request as held by the bridge
	typedef struct packed {
		logic rd;
		logic we;
		mgmt_addr_t address;
	} mgmt_req_t;

endpackage

// File: drive_dispatch.sv
module drive_dispatch import disk_pkg::*; (
	input  logic clk_sys,
	input  logic RESET,
	input  logic hdd_write,
	input  logic hdd_read,
	input  word_t hdd_writedata,
	input  drive_sel_t drive_sel,
	output drive_cmd_t [NUM_DRIVES-1:0] drive_cmd,
	output drive_sel_t drive_sel_q
);

	logic [NUM_DRIVES-1:0] strobe_any;

	always_ff @(posedge clk_sys) begin
		// Write data goes to every drive, only the strobes are steered
		for (int i = 0; i < NUM_DRIVES; i++) begin
			drive_cmd[i].writedata <= hdd_writedata;
		end

		if (RESET) begin
			for (int i = 0; i < NUM_DRIVES; i++) begin
				drive_cmd[i].write <= 1'b0;
				drive_cmd[i].read <= 1'b0;
			end
			drive_sel_q <= '0;
		end else begin
			for (int i = 0; i < NUM_DRIVES; i++) begin
				drive_cmd[i].write <= hdd_write & (drive_sel == drive_sel_t'(i));
				drive_cmd[i].read <= hdd_read & (drive_sel == drive_sel_t'(i));
			end
			// Merger needs the selection that went with this strobe
			drive_sel_q <= drive_sel;
		end
	end

	always_comb begin
		for (int i = 0; i < NUM_DRIVES; i++) begin
			strobe_any[i] = drive_cmd[i].write | drive_cmd[i].read;
		end
	end

	// Only the selected drive may ever see a strobe
	a_one_drive: assert property (@(posedge clk_sys) disable iff (RESET)
		$onehot0(strobe_any));

endmodule

// File: drive_port.sv
module drive_port import disk_pkg::*; (
	input  logic clk_sys,
	input  logic RESET,
	input  drive_cmd_t cmd_in,
	input  drive_req_t req,
	output drive_cmd_t cmd_out,
	output logic led_active
);

	// ========================================================================
	// Command path
	// ========================================================================

	// Dispatcher already registered the strobes, so no extra stage here
	assign cmd_out = cmd_in;

	// ========================================================================
	// Activity stretcher
	// ========================================================================

	led_count_t led_count;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			led_count <= '0;
		end else if (req != '0) begin
			// Any request code restarts the hold time
			led_count <= led_count_t'(LED_HOLD_CYCLES);
		end else if (led_count != '0) begin
			led_count <= led_count - 1'b1;
		end
	end

	// Lit while the hold time runs
	assign led_active = (led_count != '0);

	// A drive is either read or written in one cycle, never both
	a_no_rd_wr: assert property (@(posedge clk_sys) disable iff (RESET)
		!(cmd_out.read && cmd_out.write));

endmodule

// File: readback_merge.sv
module readback_merge import disk_pkg::*; (
	input  logic clk_sys,
	input  logic RESET,
	input  drive_sel_t drive_sel_q,
	input  word_t [NUM_DRIVES-1:0] drive_readdata,
	input  logic [NUM_DRIVES-1:0] led_active,
	output word_t hdd_readdata,
	output logic disk_led
);

	// ========================================================================
	// Sector data return
	// ========================================================================

	// Selection is one cycle behind the host, the data another one
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			hdd_readdata <= '0;
		end else begin
			hdd_readdata <= drive_readdata[drive_sel_q];
		end
	end

	// ========================================================================
	// Disk LED
	// ========================================================================

	// One LED for all drives
	assign disk_led = |led_active;

endmodule

// File: mgmt_bridge.sv
module mgmt_bridge import disk_pkg::*; (
	input  logic clk_sys,
	input  logic RESET,
	input  logic host_rd,
	input  logic host_wr,
	input  mgmt_addr_t host_addr,
	input  mgmt_data_t host_wdata,
	input  logic mgmt_wait,
	input  logic mgmt_valid,
	input  mgmt_data_t mgmt_rdata,
	output mgmt_req_t mgmt_req,
	output mgmt_data_t mgmt_wdata,
	output mgmt_data_t host_rdata,
	output logic host_wait
);

	logic req_rd;
	logic req_we;
	mgmt_addr_t req_addr;

	// ========================================================================
	// Request and wait flag
	// ========================================================================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			req_rd <= 1'b0;
			req_we <= 1'b0;
			host_wait <= 1'b0;
		end else begin
			// Bus took the request
			if (!mgmt_wait) begin
				req_rd <= 1'b0;
				req_we <= 1'b0;
			end
			if (host_rd) begin
				req_rd <= 1'b1;
			end
			if (host_wr) begin
				req_we <= 1'b1;
			end

			// Read ends with valid data, write ends on acceptance
			if (mgmt_valid || (req_we && !mgmt_wait)) begin
				host_wait <= 1'b0;
			end
			if (host_rd || host_wr) begin
				host_wait <= 1'b1;
			end
		end
	end

	// Address, write data and read data
	always_ff @(posedge clk_sys) begin
		if (host_rd || host_wr) begin
			req_addr <= host_addr;
		end
		if (host_wr) begin
			mgmt_wdata <= host_wdata;
		end
		if (mgmt_valid) begin
			host_rdata <= mgmt_rdata;
		end
	end

	assign mgmt_req = '{rd: req_rd, we: req_we, address: req_addr};

	a_rd_we_excl: assert property (@(posedge clk_sys) disable iff (RESET)
		!(req_rd && req_we));

	// Host must be stalled for as long as the bus holds a request
	a_wait_held: assert property (@(posedge clk_sys) disable iff (RESET)
		(req_rd || req_we) |-> host_wait);

endmodule

// File: reset_sequencer.sv
module reset_sequencer import disk_pkg::*; (
	input  logic clk_sys,
	input  logic RESET,
	input  logic reset_req,
	input  logic user_button,
	input  logic kbd_reset_n,
	output logic sys_reset,
	output logic cpu_reset
);

	logic [1:0] req_sync;
	logic req_seen;
	logic req_rise;
	rst_pulse_t rst_pulse;
	logic init_done;
	logic cpu_rst_q;

	// Rising edge after the second synchronizer stage
	assign req_rise = req_sync[1] & ~req_seen;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			req_sync <= '0;
			req_seen <= 1'b0;
			rst_pulse <= '0;
			init_done <= 1'b0;
		end else begin
			req_sync <= {req_sync[0], reset_req};
			req_seen <= req_sync[1];

			rst_pulse <= rst_pulse << 1;
			if (req_rise) begin
				// Restart the pulse, the system is now initialised
				rst_pulse <= '1;
				init_done <= 1'b1;
			end
		end
	end

	// Any CPU reset source, one register deep
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cpu_rst_q <= 1'b0;
		end else begin
			cpu_rst_q <= user_button | reset_req | ~kbd_reset_n;
		end
	end

	// Held in reset until the first request arrives
	assign sys_reset = rst_pulse[RESET_PULSE_CYCLES-1] | ~init_done;
	assign cpu_reset = sys_reset | cpu_rst_q;

endmodule

// File: disk_host_bridge.sv
module disk_host_bridge import disk_pkg::*; (
	input  logic clk_sys,
	input  logic RESET,

	// Host sector data
	input  logic hdd_write,
	input  logic hdd_read,
	input  word_t hdd_writedata,
	input  drive_sel_t drive_sel,
	output word_t hdd_readdata,

	// Host management access
	input  logic host_rd,
	input  logic host_wr,
	input  mgmt_addr_t host_addr,
	input  mgmt_data_t host_wdata,
	output mgmt_data_t host_rdata,
	output logic host_wait,

	// Reset sources and results
	input  logic reset_req,
	input  logic user_button,
	input  logic kbd_reset_n,
	output logic sys_reset,
	output logic cpu_reset,
	output logic disk_led,

	// Drive side
	output drive_cmd_t [NUM_DRIVES-1:0] drive_cmd,
	input  word_t [NUM_DRIVES-1:0] drive_readdata,
	input  drive_req_t [NUM_DRIVES-1:0] drive_req,

	// Management bus
	output mgmt_req_t mgmt_req,
	output mgmt_data_t mgmt_wdata,
	input  logic mgmt_wait,
	input  logic mgmt_valid,
	input  mgmt_data_t mgmt_rdata
);

	drive_cmd_t [NUM_DRIVES-1:0] dispatched_cmd;
	drive_sel_t drive_sel_q;
	logic [NUM_DRIVES-1:0] led_active;

	// ========================================================================
	// Sector data path
	// ========================================================================

	drive_dispatch drive_dispatch_i (
		.clk_sys(clk_sys),
		.RESET(RESET),
		.hdd_write(hdd_write),
		.hdd_read(hdd_read),
		.hdd_writedata(hdd_writedata),
		.drive_sel(drive_sel),
		.drive_cmd(dispatched_cmd),
		.drive_sel_q(drive_sel_q)
	);

	for (genvar i = 0; i < NUM_DRIVES; i++) begin : g_drive
		drive_port drive_port_i (
			.clk_sys(clk_sys),
			.RESET(RESET),
			.cmd_in(dispatched_cmd[i]),
			.req(drive_req[i]),
			.cmd_out(drive_cmd[i]),
			.led_active(led_active[i])
		);
	end

	readback_merge readback_merge_i (
		.clk_sys(clk_sys),
		.RESET(RESET),
		.drive_sel_q(drive_sel_q),
		.drive_readdata(drive_readdata),
		.led_active(led_active),
		.hdd_readdata(hdd_readdata),
		.disk_led(disk_led)
	);

	// ========================================================================
	// Management bus and resets
	// ========================================================================

	mgmt_bridge mgmt_bridge_i (
		.clk_sys(clk_sys),
		.RESET(RESET),
		.host_rd(host_rd),
		.host_wr(host_wr),
		.host_addr(host_addr),
		.host_wdata(host_wdata),
		.mgmt_wait(mgmt_wait),
		.mgmt_valid(mgmt_valid),
		.mgmt_rdata(mgmt_rdata),
		.mgmt_req(mgmt_req),
		.mgmt_wdata(mgmt_wdata),
		.host_rdata(host_rdata),
		.host_wait(host_wait)
	);

	reset_sequencer reset_sequencer_i (
		.clk_sys(clk_sys),
		.RESET(RESET),
		.reset_req(reset_req),
		.user_button(user_button),
		.kbd_reset_n(kbd_reset_n),
		.sys_reset(sys_reset),
		.cpu_reset(cpu_reset)
	);

endmodule

// File: tb_disk_host_bridge.sv
module tb_disk_host_bridge import disk_pkg::*; ();

	typedef enum {K_DRV_WR, K_DRV_RD, K_LED, K_MGMT_RD, K_MGMT_WR, K_RESET} test_kind_t;

	// One row of the stimulus table
	typedef struct {
		string name;
		test_kind_t kind;
		int drive;
		mgmt_addr_t addr;
		mgmt_data_t data;
		int waits;
		mgmt_data_t expected;
	} test_rec_t;

	localparam int NUM_TESTS = 10;
	// Responder answers a read with address XOR this key
	localparam mgmt_data_t ANSWER_KEY = 32'hC0DE_5A5A;

	logic clk_sys;
	logic RESET;
	logic hdd_write;
	logic hdd_read;
	word_t hdd_writedata;
	drive_sel_t drive_sel;
	word_t hdd_readdata;
	logic host_rd;
	logic host_wr;
	mgmt_addr_t host_addr;
	mgmt_data_t host_wdata;
	mgmt_data_t host_rdata;
	logic host_wait;
	logic reset_req;
	logic user_button;
	logic kbd_reset_n;
	logic sys_reset;
	logic cpu_reset;
	logic disk_led;
	drive_cmd_t [NUM_DRIVES-1:0] drive_cmd;
	word_t [NUM_DRIVES-1:0] drive_readdata;
	drive_req_t [NUM_DRIVES-1:0] drive_req;
	mgmt_req_t mgmt_req;
	mgmt_data_t mgmt_wdata;
	logic mgmt_wait;
	logic mgmt_valid;
	mgmt_data_t mgmt_rdata;

	test_rec_t tests[NUM_TESTS];
	int num_tests;
	string cur_name;
	int error_count;
	int cycle_count;
	int cycle_limit;
	int bus_waits;
	int wait_left;
	logic in_service;
	logic valid_next;
	mgmt_data_t rdata_next;
	mgmt_data_t seen_wdata;

	disk_host_bridge disk_host_bridge_i (.*);

	// ========================================================================
	// Clock, watchdog and bus models
	// ========================================================================

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	initial begin
		cycle_count = 0;
		while (cycle_limit == 0 || cycle_count < cycle_limit) begin
			@(posedge clk_sys);
			cycle_count++;
		end
		$display("Timeout: the run did not end within %0d cycles", cycle_limit);
		$display("ERRORS FOUND");
		$finish;
	end

	// Each drive answers with its index in the top nibble
	for (genvar k = 0; k < NUM_DRIVES; k++) begin : g_drive_model
		assign drive_readdata[k] = word_t'(k * 16'h1000 + 16'h0C3A);
	end

	// Management slave that stalls for bus_waits cycles per request
	initial begin
		mgmt_wait = 1'b0;
		mgmt_valid = 1'b0;
		mgmt_rdata = '0;
		valid_next = 1'b0;
		rdata_next = '0;
		in_service = 1'b0;
		wait_left = 0;
		forever begin
			@(posedge clk_sys);
			#10;
			mgmt_valid = valid_next;
			mgmt_rdata = rdata_next;
			valid_next = 1'b0;
			if (RESET || !(mgmt_req.rd || mgmt_req.we)) begin
				mgmt_wait = 1'b0;
				in_service = 1'b0;
			end else begin
				if (!in_service) begin
					in_service = 1'b1;
					wait_left = bus_waits;
				end
				if (wait_left > 0) begin
					mgmt_wait = 1'b1;
					wait_left--;
				end else begin
					// Taken at the coming edge and the read data follows a cycle later
					mgmt_wait = 1'b0;
					in_service = 1'b0;
					valid_next = mgmt_req.rd;
					rdata_next = {16'h0000, mgmt_req.address} ^ ANSWER_KEY;
					seen_wdata = mgmt_wdata;
				end
			end
		end
	end

	// ========================================================================
	// Checks and helpers
	// ========================================================================

	task automatic check_word(input string what, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			$display("Error %s %s: expected %h, actual %h", cur_name, what, expected, actual);
			error_count++;
		end
	endtask

	task automatic check_mgmt(input string what, input mgmt_data_t expected,
			input mgmt_data_t actual);
		if (actual !== expected) begin
			$display("Error %s %s: expected %h, actual %h", cur_name, what, expected, actual);
			error_count++;
		end
	endtask

	task automatic check_bit(input string what, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("Error %s %s: expected %b, actual %b", cur_name, what, expected, actual);
			error_count++;
		end
	endtask

	task automatic next_cycle();
		@(posedge clk_sys);
		#10;
	endtask

	task automatic wait_host_ready();
		int n;
		n = 0;
		while (host_wait === 1'b1 && n < 16) begin
			next_cycle();
			n++;
		end
		if (host_wait !== 1'b0) begin
			$display("Test %s: host_wait did not fall within 16 cycles", cur_name);
			error_count++;
		end
	endtask

	function automatic void add_test(input string name, input test_kind_t kind,
			input int drive, input mgmt_addr_t addr, input mgmt_data_t data,
			input int waits, input mgmt_data_t expected);
		tests[num_tests] = '{name, kind, drive, addr, data, waits, expected};
		num_tests++;
	endfunction

	function automatic int test_length(input test_rec_t rec);
		case (rec.kind)
			K_LED: return LED_HOLD_CYCLES + 2;
			K_RESET: return rec.waits + RESET_PULSE_CYCLES + 6;
			default: return rec.waits + 20;
		endcase
	endfunction

	// ========================================================================
	// Test kinds
	// ========================================================================

	task automatic write_drive(input test_rec_t rec);
		hdd_write = 1'b1;
		drive_sel = drive_sel_t'(rec.drive);
		hdd_writedata = word_t'(rec.data);
		next_cycle();
		hdd_write = 1'b0;
		for (int j = 0; j < NUM_DRIVES; j++) begin
			check_bit("write strobe", j == rec.drive, drive_cmd[j].write);
			check_bit("read strobe", 1'b0, drive_cmd[j].read);
			// Write data reaches every drive
			check_word("writedata", word_t'(rec.expected), drive_cmd[j].writedata);
		end
		next_cycle();
		check_bit("strobe cleared", 1'b0, drive_cmd[rec.drive].write);
	endtask

	task automatic read_drive(input test_rec_t rec);
		hdd_read = 1'b1;
		drive_sel = drive_sel_t'(rec.drive);
		next_cycle();
		hdd_read = 1'b0;
		check_bit("read strobe", 1'b1, drive_cmd[rec.drive].read);
		next_cycle();
		check_word("readdata", word_t'(rec.expected), hdd_readdata);
	endtask

	task automatic watch_led(input test_rec_t rec);
		check_bit("led idle", 1'b0, disk_led);
		drive_req[rec.drive] = drive_req_t'(rec.data);
		next_cycle();
		drive_req[rec.drive] = '0;
		check_bit("led on", 1'b1, disk_led);
		// Hold time counts from the request edge, one per edge
		for (int i = 1; i < LED_HOLD_CYCLES; i++) begin
			next_cycle();
			check_bit("led held", 1'b1, disk_led);
		end
		next_cycle();
		check_bit("led off", 1'b0, disk_led);
	endtask

	task automatic read_mgmt(input test_rec_t rec);
		bus_waits = rec.waits;
		host_rd = 1'b1;
		host_addr = rec.addr;
		for (int i = 0; i <= rec.waits; i++) begin
			next_cycle();
			host_rd = 1'b0;
			check_bit("rd held", 1'b1, mgmt_req.rd);
			check_bit("wait held", 1'b1, host_wait);
		end
		next_cycle();
		check_bit("rd released", 1'b0, mgmt_req.rd);
		wait_host_ready();
		check_mgmt("rdata", rec.expected, host_rdata);
	endtask

	task automatic write_mgmt(input test_rec_t rec);
		bus_waits = rec.waits;
		host_wr = 1'b1;
		host_addr = rec.addr;
		host_wdata = rec.data;
		for (int i = 0; i <= rec.waits; i++) begin
			next_cycle();
			host_wr = 1'b0;
			check_bit("we held", 1'b1, mgmt_req.we);
			check_bit("wait held", 1'b1, host_wait);
			check_mgmt("bus address", {16'h0000, rec.addr}, {16'h0000, mgmt_req.address});
			check_mgmt("bus wdata", rec.expected, mgmt_wdata);
		end
		wait_host_ready();
		check_bit("we released", 1'b0, mgmt_req.we);
		check_mgmt("accepted wdata", rec.expected, seen_wdata);
	endtask

	task automatic sequence_reset(input test_rec_t rec);
		for (int i = 0; i < rec.waits; i++) begin
			next_cycle();
			check_bit("held before request", 1'b1, sys_reset);
		end
		reset_req = 1'b1;
		// Two synchronizer stages and the edge register come before the pulse
		for (int i = 0; i < RESET_PULSE_CYCLES + 2; i++) begin
			next_cycle();
			reset_req = 1'b0;
			check_bit("pulse", 1'b1, sys_reset);
		end
		next_cycle();
		check_bit("pulse end", 1'b0, sys_reset);
		check_bit("cpu idle", 1'b0, cpu_reset);
		user_button = 1'b1;
		next_cycle();
		user_button = 1'b0;
		check_bit("cpu from button", 1'b1, cpu_reset);
		next_cycle();
		check_bit("cpu released", 1'b0, cpu_reset);
	endtask

	// ========================================================================
	// Table and main sequence
	// ========================================================================

	initial begin
		mgmt_data_t d0;
		mgmt_data_t d1;
		mgmt_data_t d2;
		int errors_before;
		int tests_failed;
		void'($urandom(77));
		d0 = {16'h0000, 16'($urandom)};
		d1 = {16'h0000, 16'($urandom)};
		d2 = $urandom;
		add_test("reset sequence", K_RESET, 0, '0, '0, 3, '0);
		add_test("write drive 0", K_DRV_WR, 0, '0, d0, 0, d0);
		add_test("write drive 1", K_DRV_WR, 1, '0, d1, 0, d1);
		add_test("read drive 0", K_DRV_RD, 0, '0, '0, 0, 32'h0000_0C3A);
		add_test("read drive 1", K_DRV_RD, 1, '0, '0, 0, 32'h0000_1C3A);
		add_test("led drive 1", K_LED, 1, '0, 32'd6, 0, 32'd1);
		add_test("led drive 0", K_LED, 0, '0, 32'd1, 0, 32'd1);
		add_test("mgmt read no wait", K_MGMT_RD, 0, 16'h0010, '0, 0, 32'hC0DE_5A4A);
		add_test("mgmt read 3 waits", K_MGMT_RD, 0, 16'h1234, '0, 3, 32'hC0DE_486E);
		add_test("mgmt write 2 waits", K_MGMT_WR, 0, 16'h00A0, d2, 2, d2);

		cycle_limit = 5 + LED_HOLD_CYCLES + 20;
		for (int t = 0; t < NUM_TESTS; t++) begin
			cycle_limit += test_length(tests[t]);
		end

		RESET = 1'b1;
		hdd_write = 1'b0;
		hdd_read = 1'b0;
		hdd_writedata = '0;
		drive_sel = '0;
		host_rd = 1'b0;
		host_wr = 1'b0;
		host_addr = '0;
		host_wdata = '0;
		reset_req = 1'b0;
		user_button = 1'b0;
		kbd_reset_n = 1'b1;
		drive_req = '0;
		bus_waits = 0;
		tests_failed = 0;
		repeat (5) @(posedge clk_sys);
		#10;
		RESET = 1'b0;

		for (int t = 0; t < NUM_TESTS; t++) begin
			cur_name = tests[t].name;
			errors_before = error_count;
			case (tests[t].kind)
				K_DRV_WR: write_drive(tests[t]);
				K_DRV_RD: read_drive(tests[t]);
				K_LED: watch_led(tests[t]);
				K_MGMT_RD: read_mgmt(tests[t]);
				K_MGMT_WR: write_mgmt(tests[t]);
				default: sequence_reset(tests[t]);
			endcase
			if (error_count == errors_before) begin
				$display("PASS %s", cur_name);
			end else begin
				$display("FAIL %s", cur_name);
				tests_failed++;
			end
		end

		$display("Tests run %0d, failed %0d, failed checks %0d",
			NUM_TESTS, tests_failed, error_count);
		if (error_count == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// File: compile.f
disk_pkg.sv
drive_dispatch.sv
drive_port.sv
readback_merge.sv
mgmt_bridge.sv
reset_sequencer.sv
disk_host_bridge.sv
tb_disk_host_bridge.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_disk_host_bridge
FILELIST = compile.f

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

# Passes only when the run prints the pass message
sim:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP)
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "NO ERRORS"

clean:
	rm -rf obj_dir
